// File: rtl/nn_params.svh
`ifndef NN_PARAMS_SVH
`define NN_PARAMS_SVH

// data path widths
`define ACT_WIDTH 8
`define WEIGHT_WIDTH 8
`define PROD_WIDTH 16
`define ACC_WIDTH 23

// requantize moves the sum down by this many fraction bits
`define FRAC_SHIFT 6
`define SAT_VALUE 127

// network shape
`define FEATURE_COUNT 6
`define HIDDEN_COUNT 15
`define CLASS_COUNT 4

`define NODE_LATENCY 3

`endif

// File: rtl/nnDataPkg.sv
`default_nettype none
`include "nn_params.svh"

package nnDataPkg;

	// signed value on every layer boundary
	typedef logic signed [`ACT_WIDTH-1:0] activation_t;

	typedef logic signed [`WEIGHT_WIDTH-1:0] weight_t;

	typedef logic signed [`PROD_WIDTH-1:0] product_t; // biases are kept in this scale too

	typedef logic signed [`ACC_WIDTH-1:0] acc_t; // holds a full row of products without overflow

	typedef logic [$clog2(`CLASS_COUNT)-1:0] classIndex_t;

endpackage

`default_nettype wire

// File: rtl/nnWeightsPkg.sv
`default_nettype none
`include "nn_params.svh"

package nnWeightsPkg;

	// layer 3 has one row per hidden node and one column per input feature
	parameter nnDataPkg::weight_t [0:`HIDDEN_COUNT-1][0:`FEATURE_COUNT-1] hiddenWeights = '{
		'{ 8'sd24, -8'sd12,  8'sd8,  8'sd30, -8'sd6,  8'sd14},
		'{-8'sd18,  8'sd40,  8'sd10, -8'sd4,  8'sd22, -8'sd8},
		'{ 8'sd12,  8'sd6,  -8'sd30,  8'sd16,  8'sd4,  8'sd28},
		'{ 8'sd36, -8'sd20,  8'sd14, -8'sd10,  8'sd8,  8'sd2},
		'{-8'sd6,   8'sd18,  8'sd26,  8'sd12, -8'sd14,  8'sd20},
		'{ 8'sd10, -8'sd28,  8'sd4,   8'sd34,  8'sd16, -8'sd12},
		'{ 8'sd20,  8'sd14, -8'sd8,  -8'sd16,  8'sd30,  8'sd6},
		'{-8'sd24,  8'sd8,   8'sd32,  8'sd6,  -8'sd10,  8'sd18},
		'{ 8'sd16,  8'sd22, -8'sd12,  8'sd8,   8'sd26, -8'sd20},
		'{ 8'sd4,  -8'sd10,  8'sd18,  8'sd28,  8'sd12,  8'sd10},
		'{ 8'sd30,  8'sd12,  8'sd6,  -8'sd22, -8'sd8,   8'sd24},
		'{-8'sd14,  8'sd26, -8'sd18,  8'sd14,  8'sd20,  8'sd8},
		'{ 8'sd8,  -8'sd6,   8'sd22,  8'sd10, -8'sd26,  8'sd32},
		'{ 8'sd28,  8'sd16,  8'sd12, -8'sd8,   8'sd6,  -8'sd18},
		'{-8'sd10,  8'sd34, -8'sd4,   8'sd20,  8'sd14,  8'sd12}
	};

	parameter nnDataPkg::product_t [0:`HIDDEN_COUNT-1] hiddenBias = '{
		16'sd128, -16'sd256, 16'sd64, 16'sd0, -16'sd128,
		16'sd192, 16'sd32, -16'sd64, 16'sd96, 16'sd0,
		-16'sd192, 16'sd160, 16'sd48, -16'sd32, 16'sd224
	};

	// row 0 is the reference output node
	parameter nnDataPkg::weight_t [0:`CLASS_COUNT-1][0:`HIDDEN_COUNT-1] outputWeights = '{
		'{ 8'sd32, -8'sd10, -8'sd26,  8'sd38,  8'sd4,  -8'sd6,   8'sd2,  -8'sd6,
			-8'sd8,  -8'sd32,  8'sd26, -8'sd52,  8'sd26,  8'sd8,   8'sd10},
		'{-8'sd12,  8'sd24,  8'sd18, -8'sd8,   8'sd30,  8'sd10, -8'sd20,  8'sd14,
			8'sd6,   8'sd22, -8'sd16,  8'sd12, -8'sd4,   8'sd28, -8'sd6},
		'{ 8'sd20,  8'sd8,  -8'sd14,  8'sd26, -8'sd10,  8'sd34,  8'sd12, -8'sd6,
			8'sd18, -8'sd8,   8'sd4,   8'sd16,  8'sd22, -8'sd12,  8'sd14},
		'{-8'sd4,  -8'sd16,  8'sd28,  8'sd10,  8'sd18, -8'sd20,  8'sd30,  8'sd24,
			-8'sd10,  8'sd12,  8'sd8,  -8'sd6,   8'sd16,  8'sd20, -8'sd14}
	};

	parameter nnDataPkg::product_t [0:`CLASS_COUNT-1] outputBias = '{
		16'sd0, 16'sd64, -16'sd128, 16'sd32
	};

endpackage

`default_nettype wire

// File: rtl/neuronNode.sv
`timescale 1ns/1ps
`default_nettype none
`include "nn_params.svh"

module neuronNode #(
	parameter int INPUTS = `FEATURE_COUNT,
	parameter nnDataPkg::weight_t [0:INPUTS-1] WEIGHTS = '0,
	parameter nnDataPkg::product_t BIAS = '0
) (
	input logic clk,
	input logic reset,
	input nnDataPkg::activation_t acts [INPUTS],
	output nnDataPkg::activation_t result
);

	localparam nnDataPkg::acc_t HALF = nnDataPkg::acc_t'(1) <<< (`FRAC_SHIFT - 1);
	localparam nnDataPkg::acc_t FRAC_MASK = (HALF <<< 1) - 1;

	nnDataPkg::activation_t actReg [INPUTS];
	nnDataPkg::product_t products [INPUTS];
	nnDataPkg::acc_t sum;
	nnDataPkg::acc_t accReg;

	// ReLU, then drop the fraction bits with round-half-down and clip at the top
	function automatic nnDataPkg::activation_t requantize(input nnDataPkg::acc_t value);
		nnDataPkg::acc_t whole;
		whole = value >>> `FRAC_SHIFT;
		if ((value & FRAC_MASK) > HALF)
		begin
			whole = whole + 1; // an exact half is not rounded up
		end
		if (value < 0)
		begin
			requantize = '0;
		end
		else if (whole > `SAT_VALUE)
		begin
			requantize = nnDataPkg::activation_t'(`SAT_VALUE);
		end
		else
		begin
			requantize = nnDataPkg::activation_t'(whole);
		end
	endfunction

	always_comb
	begin
		sum = nnDataPkg::acc_t'(BIAS);
		for (int i = 0; i < INPUTS; i++)
		begin
			products[i] = actReg[i] * nnDataPkg::weight_t'(WEIGHTS[i]);
			sum = sum + nnDataPkg::acc_t'(products[i]); // the cast sign-extends each product
		end
	end

	// three register stages: inputs, sum, requantized result
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '{default: '0};
			accReg <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= acts;
			accReg <= sum;
			result <= requantize(accReg);
		end
	end

	resultRange: assert property (@(posedge clk) disable iff (reset)
		$unsigned(result) <= `SAT_VALUE)
		else $error("neuronNode result %0d is outside 0..%0d", result, `SAT_VALUE);

endmodule

`default_nettype wire

// File: rtl/denseLayer.sv
`timescale 1ns/1ps
`default_nettype none
`include "nn_params.svh"

module denseLayer #(
	parameter int INPUTS = `FEATURE_COUNT,
	parameter int NODES = `HIDDEN_COUNT,
	parameter nnDataPkg::weight_t [0:NODES-1][0:INPUTS-1] WEIGHTS = '0,
	parameter nnDataPkg::product_t [0:NODES-1] BIASES = '0
) (
	input logic clk,
	input logic reset,
	input nnDataPkg::activation_t acts [INPUTS],
	input logic inValid,
	output nnDataPkg::activation_t results [NODES],
	output logic outValid
);

	logic [`NODE_LATENCY-1:0] validPipe;

	// every node sees the same activations and takes its own weight row
	for (genvar n = 0; n < NODES; n++)
	begin : gNode
		neuronNode #(
			.INPUTS(INPUTS),
			.WEIGHTS(WEIGHTS[n]),
			.BIAS(BIASES[n])
		) node (
			.clk(clk),
			.reset(reset),
			.acts(acts),
			.result(results[n])
		);
	end

	// the strobe walks beside the data through the node registers
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[`NODE_LATENCY-2:0], inValid};
		end
	end

	assign outValid = validPipe[`NODE_LATENCY-1];

	validArrives: assert property (@(posedge clk) disable iff (reset)
		inValid |-> ##(`NODE_LATENCY) outValid)
		else $error("denseLayer lost a valid strobe");

	validMatched: assert property (@(posedge clk) disable iff (reset)
		outValid |-> $past(inValid, `NODE_LATENCY))
		else $error("denseLayer raised outValid with no matching inValid");

endmodule

`default_nettype wire

// File: rtl/classSelect.sv
`timescale 1ns/1ps
`default_nettype none
`include "nn_params.svh"

module classSelect (
	input logic clk,
	input logic reset,
	input nnDataPkg::activation_t scores [`CLASS_COUNT],
	input logic scoreValid,
	output nnDataPkg::classIndex_t classIndex,
	output nnDataPkg::activation_t classScore,
	output logic classValid
);

	nnDataPkg::classIndex_t bestIndex;
	nnDataPkg::activation_t bestScore;

	always_comb
	begin
		bestIndex = '0;
		bestScore = scores[0];
		for (int i = 1; i < `CLASS_COUNT; i++)
		begin
			if (scores[i] > bestScore) // strict compare so a tie keeps the lower index
			begin
				bestIndex = nnDataPkg::classIndex_t'(i);
				bestScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIndex <= '0;
			classScore <= '0;
			classValid <= 1'b0;
		end
		else
		begin
			classIndex <= bestIndex;
			classScore <= bestScore;
			classValid <= scoreValid;
		end
	end

	validFollows: assert property (@(posedge clk) disable iff (reset)
		scoreValid |=> classValid)
		else $error("classValid missing one cycle after scoreValid");

	noExtraValid: assert property (@(posedge clk) disable iff (reset)
		classValid |-> $past(scoreValid))
		else $error("classValid raised without scoreValid");

endmodule

`default_nettype wire

// File: rtl/mlpClassifier.sv
`timescale 1ns/1ps
`default_nettype none
`include "nn_params.svh"

module mlpClassifier (
	input logic clk,
	input logic reset,
	input nnDataPkg::activation_t features [`FEATURE_COUNT],
	input logic inValid,
	output nnDataPkg::activation_t scores [`CLASS_COUNT],
	output logic scoreValid,
	output nnDataPkg::classIndex_t classIndex,
	output nnDataPkg::activation_t classScore,
	output logic classValid
);

	nnDataPkg::activation_t hiddenActs [`HIDDEN_COUNT];
	logic hiddenValid;

	denseLayer #(
		.INPUTS(`FEATURE_COUNT),
		.NODES(`HIDDEN_COUNT),
		.WEIGHTS(nnWeightsPkg::hiddenWeights),
		.BIASES(nnWeightsPkg::hiddenBias)
	) layer3 (
		.clk(clk),
		.reset(reset),
		.acts(features),
		.inValid(inValid),
		.results(hiddenActs),
		.outValid(hiddenValid)
	);

	denseLayer #(
		.INPUTS(`HIDDEN_COUNT),
		.NODES(`CLASS_COUNT),
		.WEIGHTS(nnWeightsPkg::outputWeights),
		.BIASES(nnWeightsPkg::outputBias)
	) layer4 (
		.clk(clk),
		.reset(reset),
		.acts(hiddenActs),
		.inValid(hiddenValid),
		.results(scores),
		.outValid(scoreValid)
	);

	classSelect selector (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.scoreValid(scoreValid),
		.classIndex(classIndex),
		.classScore(classScore),
		.classValid(classValid)
	);

endmodule

`default_nettype wire

// File: tb/mlpClassifier_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "nn_params.svh"

module mlpClassifier_tb;

	localparam int MAX_VECTORS = 64;
	localparam int CLK_PERIOD = 40;

	logic clk;
	logic reset;
	nnDataPkg::activation_t features [`FEATURE_COUNT];
	logic inValid;
	nnDataPkg::activation_t scores [`CLASS_COUNT];
	logic scoreValid;
	nnDataPkg::classIndex_t classIndex;
	nnDataPkg::activation_t classScore;
	logic classValid;

	int vecFeatures [MAX_VECTORS][`FEATURE_COUNT];
	int vecScores [MAX_VECTORS][`CLASS_COUNT];
	int vecClass [MAX_VECTORS];
	int vectorCount = 0;

	int cycle = 0;
	int errorCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int unsigned lcgState = 32'd43386;

	// vector index and expected arrival cycle for each result still in flight
	int pendScoreVec [$];
	int pendScoreAt [$];
	int pendClassVec [$];
	int pendClassAt [$];

	mlpClassifier dut0 (
		.clk(clk),
		.reset(reset),
		.features(features),
		.inValid(inValid),
		.scores(scores),
		.scoreValid(scoreValid),
		.classIndex(classIndex),
		.classScore(classScore),
		.classValid(classValid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
	end

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 16;
	endfunction

	task automatic reportValue(input string name, input int expected, input int actual);
		$display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
		errorCount++;
	endtask

	task automatic loadVectors();
		int fd;
		int n;
		string line;
		int f [`FEATURE_COUNT];
		int s [`CLASS_COUNT];
		int c;
		fd = $fopen("tb/mlp_input.txt", "r");
		if (fd == 0)
		begin
			$display("could not open tb/mlp_input.txt");
			errorCount++;
			return;
		end
		while (!$feof(fd) && vectorCount < MAX_VECTORS)
		begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2], f[3],
				f[4], f[5], s[0], s[1], s[2], s[3], c);
			if (n != 11)
			begin
				$display("malformed line in the vector file: %s", line);
				errorCount++;
				continue;
			end
			for (int i = 0; i < `FEATURE_COUNT; i++)
				vecFeatures[vectorCount][i] = f[i];
			for (int i = 0; i < `CLASS_COUNT; i++)
				vecScores[vectorCount][i] = s[i];
			vecClass[vectorCount] = c;
			vectorCount++;
		end
		$fclose(fd);
	endtask

	// called right after a rising edge; the DUT takes the vector on the next one
	task automatic driveVector(input int idx);
		for (int i = 0; i < `FEATURE_COUNT; i++)
			features[i] <= nnDataPkg::activation_t'(vecFeatures[idx][i]);
		inValid <= 1'b1;
		pendScoreVec.push_back(idx);
		pendScoreAt.push_back(cycle + 1 + 6);
		pendClassVec.push_back(idx);
		pendClassAt.push_back(cycle + 1 + 7);
		@(posedge clk);
	endtask

	task automatic driveIdle();
		inValid <= 1'b0;
		@(posedge clk);
	endtask

	task automatic waitDrained();
		while (pendClassVec.size() != 0 || pendScoreVec.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk); // room for any stray strobe to show up
	endtask

	task automatic finishTest(input string name, input int startErrors);
		if (errorCount == startErrors)
		begin
			testsPassed++;
			$display("test %s: ok", name);
		end
		else
		begin
			testsFailed++;
			$display("test %s: %0d errors", name, errorCount - startErrors);
		end
	endtask

	// compares results at the falling edge, where outputs are settled
	always @(negedge clk)
	begin : resultMonitor
		int v;
		if (!reset)
		begin
			if (pendScoreAt.size() != 0 && !scoreValid && cycle > pendScoreAt[0])
			begin
				$display("scoreValid never came for vector %0d", pendScoreVec[0]);
				errorCount++;
				void'(pendScoreVec.pop_front());
				void'(pendScoreAt.pop_front());
			end
			if (pendClassAt.size() != 0 && !classValid && cycle > pendClassAt[0])
			begin
				$display("classValid never came for vector %0d", pendClassVec[0]);
				errorCount++;
				void'(pendClassVec.pop_front());
				void'(pendClassAt.pop_front());
			end
			if (scoreValid)
			begin
				if (pendScoreVec.size() == 0)
				begin
					$display("scoreValid high at %0t with no vector in flight", $time);
					errorCount++;
				end
				else
				begin
					v = pendScoreVec.pop_front();
					if (cycle != pendScoreAt[0])
						reportValue("scoreValid cycle", pendScoreAt[0], cycle);
					void'(pendScoreAt.pop_front());
					for (int i = 0; i < `CLASS_COUNT; i++)
						if (int'(scores[i]) != vecScores[v][i])
							reportValue($sformatf("scores[%0d]", i), vecScores[v][i],
								int'(scores[i]));
				end
			end
			if (classValid)
			begin
				if (pendClassVec.size() == 0)
				begin
					$display("classValid high at %0t with no vector in flight", $time);
					errorCount++;
				end
				else
				begin
					v = pendClassVec.pop_front();
					if (cycle != pendClassAt[0])
						reportValue("classValid cycle", pendClassAt[0], cycle);
					void'(pendClassAt.pop_front());
					if (int'(classIndex) != vecClass[v])
						reportValue("classIndex", vecClass[v], int'(classIndex));
					if (int'(classScore) != vecScores[v][vecClass[v]])
						reportValue("classScore", vecScores[v][vecClass[v]], int'(classScore));
				end
			end
		end
	end

	// ends a hung run; budget is ten cycles a vector plus setup
	initial
	begin
		wait (vectorCount > 0);
		#((vectorCount * 10 + 100) * CLK_PERIOD);
		$display("watchdog expired before all vectors came out");
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		int startErrors;
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		for (int i = 0; i < `FEATURE_COUNT; i++)
			features[i] = '0;

		loadVectors();
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		startErrors = errorCount;
		@(negedge clk);
		// the output registers still hold their cleared values before the bias path fills in
		for (int i = 0; i < `CLASS_COUNT; i++)
			if (scores[i] != '0)
				reportValue($sformatf("scores[%0d]", i), 0, int'(scores[i]));
		repeat (10)
		begin
			if (scoreValid)
				reportValue("scoreValid", 0, 1);
			if (classValid)
				reportValue("classValid", 0, 1);
			@(negedge clk);
		end
		finishTest("reset state", startErrors);

		@(posedge clk);
		startErrors = errorCount;
		for (int v = 0; v < vectorCount; v++)
			driveVector(v);
		driveIdle();
		waitDrained();
		finishTest("back-to-back stream", startErrors);

		startErrors = errorCount;
		for (int v = 0; v < vectorCount; v++)
		begin
			driveVector(v);
			repeat (nextRandom() % 4)
				driveIdle();
		end
		driveIdle();
		waitDrained();
		finishTest("gapped stream", startErrors);

		if (vectorCount == 0)
		begin
			$display("no vectors were loaded");
			testsFailed++;
		end

		$display("tests passed %0d failed %0d", testsPassed, testsFailed);
		if (errorCount == 0 && testsFailed == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/nnDataPkg.sv
rtl/nnWeightsPkg.sv
rtl/neuronNode.sv
rtl/denseLayer.sv
rtl/classSelect.sv
rtl/mlpClassifier.sv
tb/mlpClassifier_tb.sv

// File: run.sh
#!/bin/sh
# builds the classifier testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f \
	--top-module mlpClassifier_tb -Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "^Testbench passed$" sim.log
then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// File: tb/mlp_input.txt
# columns: six signed features, four expected scores (class 0..3), expected class index
# all zero input gives the bias only path, row 1 lands on an exact half
0 0 0 0 0 0 0 1 2 0 2
3 0 0 0 0 0 1 2 3 0 2
10 0 0 0 0 0 6 1 7 4 2
11 0 0 0 0 0 6 1 7 4 2
12 0 0 0 0 0 8 1 7 4 0
# rows 0 and 2 tie on the top score so class 0 wins
12 0 0 0 1 0 7 1 7 5 0
100 0 0 0 0 0 66 0 50 44 0
127 0 0 127 0 0 44 42 106 27 2
# hidden node 0 saturates here
127 0 0 127 0 127 64 38 111 89 2
